// File: hw/cop0_pkg.sv
package cop0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [4:0]  cp0_sel_t;

    // Cause.ExcCode values.
    localparam exc_code_t EXCCODE_ADEL = 5'h4;
    localparam exc_code_t EXCCODE_ADES = 5'h5;
    localparam exc_code_t EXCCODE_SYS  = 5'h8;
    localparam exc_code_t EXCCODE_BP   = 5'h9;
    localparam exc_code_t EXCCODE_RI   = 5'hA;
    localparam exc_code_t EXCCODE_CU   = 5'hB;
    localparam exc_code_t EXCCODE_OV   = 5'hC;
    localparam exc_code_t EXCCODE_TR   = 5'hD;

    typedef enum logic [2:0] {
        EXC_CHK_NONE,
        EXC_CHK_SYSCALL,
        EXC_CHK_BREAK,
        EXC_CHK_TRAP,
        EXC_CHK_ERET
    } exc_chk_e;

    typedef enum logic [2:0] {
        TRAP_EQ,
        TRAP_NE,
        TRAP_GE,
        TRAP_GEU,
        TRAP_LT,
        TRAP_LTU
    } trap_cond_e;

    typedef enum logic [1:0] {
        PC_SRC_NEXT,
        PC_SRC_BRANCH,
        PC_SRC_JUMP,
        PC_SRC_JR
    } pc_src_e;

    localparam cp0_sel_t CP0_STATUS = 5'd12;
    localparam cp0_sel_t CP0_CAUSE  = 5'd13;
    localparam cp0_sel_t CP0_EPC    = 5'd14;
    localparam cp0_sel_t CP0_EBASE  = 5'd15;

    localparam int IDX_STATUS_EXL = 1;
    localparam int IDX_STATUS_BEV = 22;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        exc_chk_e   exc_chk;
        trap_cond_e trap_cond;
        word_t      rs_value;
        word_t      rt_value;
    } exe_stage_t;

    typedef struct packed {
        logic    valid;
        pc_src_e pc_src;
    } mem_stage_t;

    typedef struct packed {
        word_t status;
        word_t ebase;
        word_t epc;
    } cp0_state_t;

    typedef struct packed {
        logic      exception_happen;
        logic      eret;
        exc_code_t exc_code;
        logic      in_bd;
        word_t     epc;
        word_t     target;
    } exc_data_t;

    typedef struct packed {
        logic     en;
        cp0_sel_t sel;
        word_t    data;
    } cp0_write_t;

endpackage

// File: hw/trap_evaluator.sv
`timescale 1ns/1ps

module trap_evaluator (
    input  cop0_pkg::trap_cond_e trap_cond,
    input  cop0_pkg::word_t      rs_value,
    input  cop0_pkg::word_t      rt_value,
    output logic                 trap_taken
);
    import cop0_pkg::*;

    logic equal;
    logic less_signed;
    logic less_unsigned;

    assign equal         = (rs_value == rt_value);
    assign less_signed   = ($signed(rs_value) < $signed(rt_value));
    assign less_unsigned = (rs_value < rt_value);

    // GE and LT share one comparator each way.
    always_comb begin
        case (trap_cond)
            TRAP_EQ: begin
                trap_taken = equal;
            end
            TRAP_NE: begin
                trap_taken = !equal;
            end
            TRAP_GE: begin
                trap_taken = !less_signed;
            end
            TRAP_GEU: begin
                trap_taken = !less_unsigned;
            end
            TRAP_LT: begin
                trap_taken = less_signed;
            end
            TRAP_LTU: begin
                trap_taken = less_unsigned;
            end
            default: begin
                trap_taken = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/exception_controller.sv
`timescale 1ns/1ps

module exception_controller (
    input  cop0_pkg::exe_stage_t exe,
    input  cop0_pkg::mem_stage_t mem,
    input  logic                 trap_taken,
    input  cop0_pkg::cp0_state_t cp0_state,
    output cop0_pkg::exc_data_t  exc_data
);
    import cop0_pkg::*;

    localparam word_t BOOT_VECTOR = 32'hBFC0_0200;
    localparam word_t EXC_OFFSET  = 32'h0000_0180;

    logic  exc_happen;
    logic  in_delay_slot;
    word_t exc_vector;

    // Exception code and request decode.
    always_comb begin
        exc_happen        = 1'b1;
        exc_data.eret     = 1'b0;
        exc_data.exc_code = '0;
        case (exe.exc_chk)
            EXC_CHK_SYSCALL: begin
                exc_data.exc_code = EXCCODE_SYS;
            end
            EXC_CHK_BREAK: begin
                exc_data.exc_code = EXCCODE_BP;
            end
            EXC_CHK_TRAP: begin
                exc_data.exc_code = EXCCODE_TR;
                exc_happen        = trap_taken;
            end
            EXC_CHK_ERET: begin
                exc_happen    = 1'b0;
                exc_data.eret = 1'b1;
            end
            default: begin
                exc_happen = 1'b0;
            end
        endcase
        exc_data.exception_happen = exc_happen;
    end

    // A taken control transfer in MEM puts the EXE instruction in its slot.
    assign in_delay_slot = mem.valid && (mem.pc_src != PC_SRC_NEXT);

    always_comb begin
        if (in_delay_slot) begin
            exc_data.epc   = exe.pc - 32'd4;
            exc_data.in_bd = 1'b1;
        end else begin
            exc_data.epc   = exe.pc;
            exc_data.in_bd = 1'b0;
        end
    end

    always_comb begin
        if (cp0_state.status[IDX_STATUS_BEV]) begin
            exc_vector = BOOT_VECTOR + EXC_OFFSET;
        end else begin
            exc_vector = cp0_state.ebase + EXC_OFFSET;
        end
    end

    // ERET returns to the saved EPC.
    always_comb begin
        if (exc_data.eret) begin
            exc_data.target = cp0_state.epc;
        end else begin
            exc_data.target = exc_vector;
        end
    end

endmodule

// File: hw/cop0_regs.sv
`timescale 1ns/1ps

module cop0_regs #(
    parameter cop0_pkg::word_t RESET_EBASE = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cop0_pkg::cp0_write_t cp0_wr,
    input  cop0_pkg::cp0_sel_t   rd_sel,
    output cop0_pkg::word_t      rdata,
    input  logic                 commit_en,
    input  cop0_pkg::exc_data_t  commit,
    output cop0_pkg::cp0_state_t cp0_state
);
    import cop0_pkg::*;

    localparam word_t STATUS_RESET = word_t'(1) << IDX_STATUS_BEV;
    localparam int    IDX_CAUSE_BD = 31;

    word_t status;
    word_t cause;
    word_t epc;
    word_t ebase;

    logic status_wr;
    logic ebase_wr;

    assign status_wr = cp0_wr.en && (cp0_wr.sel == CP0_STATUS);
    assign ebase_wr  = cp0_wr.en && (cp0_wr.sel == CP0_EBASE);

    // Commit assignments come last so they win over a move-to on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= STATUS_RESET;
            cause  <= '0;
            epc    <= '0;
            ebase  <= RESET_EBASE;
        end else begin
            if (status_wr) begin
                status <= cp0_wr.data;
            end
            if (ebase_wr) begin
                // Vector base is kept 4 KB aligned.
                ebase <= {cp0_wr.data[31:12], 12'h000};
            end
            if (commit_en) begin
                if (commit.exception_happen) begin
                    cause[IDX_CAUSE_BD] <= commit.in_bd;
                    cause[6:2]          <= commit.exc_code;
                    status[IDX_STATUS_EXL] <= 1'b1;
                    // Nested exception keeps the first return address.
                    if (!status[IDX_STATUS_EXL]) begin
                        epc <= commit.epc;
                    end
                end else if (commit.eret) begin
                    status[IDX_STATUS_EXL] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (rd_sel)
            CP0_STATUS: begin
                rdata = status;
            end
            CP0_CAUSE: begin
                rdata = cause;
            end
            CP0_EPC: begin
                rdata = epc;
            end
            CP0_EBASE: begin
                rdata = ebase;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

    assign cp0_state.status = status;
    assign cp0_state.ebase  = ebase;
    assign cp0_state.epc    = epc;

    // No commit may land on the first edge out of reset.
    a_no_commit_at_reset_release: assert property (
        @(posedge clk) $rose(rst_n) |-> !commit_en
    ) else $error("commit_en high at reset release");

endmodule

// File: hw/redirect_handshake.sv
`timescale 1ns/1ps

module redirect_handshake (
    input  logic                clk,
    input  logic                rst_n,
    input  cop0_pkg::exc_data_t exc_data,
    input  logic                exe_valid,
    output logic                commit_en,
    output cop0_pkg::exc_data_t commit,
    output logic                redirect_req,
    input  logic                redirect_ack,
    output cop0_pkg::word_t     redirect_pc,
    output logic                stall
);
    import cop0_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } hs_state_e;

    hs_state_e state;
    hs_state_e state_next;
    word_t     target_q;

    // Accept only from idle, so a held request waits out the handshake.
    assign commit_en = (state == IDLE) && exe_valid &&
                       (exc_data.exception_happen || exc_data.eret);
    assign commit    = exc_data;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (commit_en) begin
                    state_next = REQ;
                end
            end
            REQ: begin
                if (redirect_ack) begin
                    state_next = WAIT_ACK_LOW;
                end
            end
            WAIT_ACK_LOW: begin
                if (!redirect_ack) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_en) begin
            target_q <= exc_data.target;
        end
    end

    assign redirect_req = (state == REQ);
    assign redirect_pc  = target_q;
    assign stall        = (state != IDLE);

    // Fetch address holds from req rising until ack falls.
    a_pc_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state != IDLE) && $past(state != IDLE) |-> $stable(redirect_pc)
    ) else $error("redirect_pc changed during handshake");

    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(redirect_req) |-> !$past(redirect_ack)
    ) else $error("redirect_req rose while ack high");

endmodule

// File: hw/exception_unit.sv
`timescale 1ns/1ps

module exception_unit #(
    parameter cop0_pkg::word_t RESET_EBASE = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cop0_pkg::exe_stage_t exe,
    input  cop0_pkg::mem_stage_t mem,
    input  cop0_pkg::cp0_write_t cp0_wr,
    input  cop0_pkg::cp0_sel_t   cp0_rd_sel,
    output cop0_pkg::word_t      cp0_rdata,
    output logic                 redirect_req,
    input  logic                 redirect_ack,
    output cop0_pkg::word_t      redirect_pc,
    output logic                 stall
);
    import cop0_pkg::*;

    logic       trap_taken;
    exc_data_t  exc_data;
    exc_data_t  commit;
    logic       commit_en;
    cp0_state_t cp0_state;

    trap_evaluator i_trap_evaluator (
        .trap_cond  (exe.trap_cond),
        .rs_value   (exe.rs_value),
        .rt_value   (exe.rt_value),
        .trap_taken (trap_taken)
    );

    exception_controller i_exception_controller (
        .exe        (exe),
        .mem        (mem),
        .trap_taken (trap_taken),
        .cp0_state  (cp0_state),
        .exc_data   (exc_data)
    );

    cop0_regs #(
        .RESET_EBASE (RESET_EBASE)
    ) i_cop0_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cp0_wr    (cp0_wr),
        .rd_sel    (cp0_rd_sel),
        .rdata     (cp0_rdata),
        .commit_en (commit_en),
        .commit    (commit),
        .cp0_state (cp0_state)
    );

    redirect_handshake i_redirect_handshake (
        .clk          (clk),
        .rst_n        (rst_n),
        .exc_data     (exc_data),
        .exe_valid    (exe.valid),
        .commit_en    (commit_en),
        .commit       (commit),
        .redirect_req (redirect_req),
        .redirect_ack (redirect_ack),
        .redirect_pc  (redirect_pc),
        .stall        (stall)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset released on a falling edge after four cycles.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: dv/exception_unit_checker.sv
`timescale 1ns/1ps

module exception_unit_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect_req,
    input  logic               redirect_ack,
    input  cop0_pkg::word_t    redirect_pc,
    input  logic               stall,
    input  cop0_pkg::cp0_sel_t cp0_rd_sel,
    input  cop0_pkg::word_t    cp0_rdata,
    input  logic               exp_req,
    input  cop0_pkg::word_t    exp_pc,
    input  logic               rd_check,
    input  cop0_pkg::word_t    rd_exp,
    input  logic               test_done,
    input  int                 test_num,
    output int                 pass_count,
    output int                 fail_count,
    output int                 error_total
);
    import cop0_pkg::*;

    logic  req_q;
    logic  ack_q;
    logic  stall_q;
    word_t pc_q;
    int    test_errors;

    task automatic report_value(input string name, input word_t expected, input word_t actual);
        $display("ERR %s expected %08h got %08h at %0t", name, expected, actual, $time);
        test_errors++;
        error_total++;
    endtask

    task automatic report_event(input string what);
        $display("test %0d: %s at %0t", test_num, what, $time);
        test_errors++;
        error_total++;
    endtask

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        error_total = 0;
        test_errors = 0;
        req_q       = 1'b0;
        ack_q       = 1'b0;
        stall_q     = 1'b0;
        pc_q        = '0;
    end

    // Values seen here are the ones held through the cycle that just ended.
    always @(posedge clk) begin
        if (rst_n) begin
            if (stall && !exp_req) begin
                report_event("stall went high with no exception pending");
            end
            if (redirect_req && !req_q) begin
                if (stall_q) begin
                    report_event("redirect_req rose while a handshake was still busy");
                end
                if (ack_q) begin
                    report_event("redirect_req rose while redirect_ack was high");
                end
                if (redirect_pc !== exp_pc) begin
                    report_value("redirect_pc", exp_pc, redirect_pc);
                end
            end
            if (stall && !stall_q && !redirect_req) begin
                report_event("redirect_req missing in the cycle after acceptance");
            end
            if (req_q && !ack_q && !redirect_req) begin
                report_event("redirect_req dropped before redirect_ack");
            end
            if (req_q && ack_q && redirect_req) begin
                report_event("redirect_req still high a cycle after redirect_ack");
            end
            // Waiting for ack low with ack already low ends the handshake.
            if (stall && stall_q && !req_q && !ack_q) begin
                report_event("stall still high a cycle after redirect_ack fell");
            end
            if (stall && stall_q && (redirect_pc !== pc_q)) begin
                report_value("redirect_pc", pc_q, redirect_pc);
            end
            if (rd_check && (cp0_rdata !== rd_exp)) begin
                report_value($sformatf("cp0_rdata(sel %02h)", cp0_rd_sel), rd_exp, cp0_rdata);
            end
            if (test_done) begin
                if (test_errors == 0) begin
                    pass_count++;
                    $display("test %0d passed", test_num);
                end else begin
                    fail_count++;
                    $display("test %0d failed with %0d errors", test_num, test_errors);
                end
                test_errors = 0;
            end
        end
        req_q   = redirect_req;
        ack_q   = redirect_ack;
        stall_q = stall;
        pc_q    = redirect_pc;
    end

endmodule

// File: dv/exception_unit_tb.sv
`timescale 1ns/1ps

module exception_unit_tb;
    import cop0_pkg::*;

    localparam int         MAX_TESTS   = 64;
    localparam logic [1:0] OP_REDIRECT = 2'd0;
    localparam logic [1:0] OP_WRITE    = 2'd1;
    localparam logic [1:0] OP_READ     = 2'd2;

    typedef struct packed {
        logic [1:0] op;
        word_t      pc;
        logic [2:0] chk;
        logic [2:0] cond;
        word_t      rs;
        word_t      rt;
        logic       mval;
        logic [1:0] psrc;
        cp0_sel_t   sel;
        word_t      data;
        logic [3:0] delay;
        logic [1:0] xreq;
        word_t      xpc;
        word_t      xepc;
        exc_code_t  xcode;
        logic       xbd;
    } test_vec_t;

    logic       clk;
    logic       rst_n;
    exe_stage_t exe;
    mem_stage_t mem;
    cp0_write_t cp0_wr;
    cp0_sel_t   cp0_rd_sel;
    word_t      cp0_rdata;
    logic       redirect_req;
    logic       redirect_ack;
    word_t      redirect_pc;
    logic       stall;

    logic      exp_req;
    word_t     exp_pc;
    logic      rd_check;
    word_t     rd_exp;
    logic      test_done;
    int        test_num;
    int        pass_count;
    int        fail_count;
    int        error_total;
    int        ack_delay;
    int        num_tests;
    int        cycle_limit;
    int        cycles;
    test_vec_t tests [MAX_TESTS];

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exception_unit #(
        .RESET_EBASE (32'h8000_0000)
    ) i_exception_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe          (exe),
        .mem          (mem),
        .cp0_wr       (cp0_wr),
        .cp0_rd_sel   (cp0_rd_sel),
        .cp0_rdata    (cp0_rdata),
        .redirect_req (redirect_req),
        .redirect_ack (redirect_ack),
        .redirect_pc  (redirect_pc),
        .stall        (stall)
    );

    exception_unit_checker i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect_req (redirect_req),
        .redirect_ack (redirect_ack),
        .redirect_pc  (redirect_pc),
        .stall        (stall),
        .cp0_rd_sel   (cp0_rd_sel),
        .cp0_rdata    (cp0_rdata),
        .exp_req      (exp_req),
        .exp_pc       (exp_pc),
        .rd_check     (rd_check),
        .rd_exp       (rd_exp),
        .test_done    (test_done),
        .test_num     (test_num),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .error_total  (error_total)
    );

    task automatic load_tests(output int count, output int worst_delay);
        int               fd;
        int               n;
        logic [63:0]      tok;
        logic [8*160-1:0] rest;
        logic [31:0]      f [0:14];
        test_vec_t        v;
        count       = 0;
        worst_delay = 0;
        fd = $fopen("dv/exception_unit_tests.txt", "r");
        if (fd == 0) begin
            count = -1;
        end else begin
            while (!$feof(fd) && (count < MAX_TESTS)) begin
                tok = '0;
                n = $fscanf(fd, "%s", tok);
                if ((n == 1) && (tok == "#")) begin
                    n = $fgets(rest, fd);
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
                    if (tok == "read") begin
                        v.op = OP_READ;
                    end else if (tok == "write") begin
                        v.op = OP_WRITE;
                    end else begin
                        v.op = OP_REDIRECT;
                    end
                    v.pc    = f[0];
                    v.chk   = f[1][2:0];
                    v.cond  = f[2][2:0];
                    v.rs    = f[3];
                    v.rt    = f[4];
                    v.mval  = f[5][0];
                    v.psrc  = f[6][1:0];
                    v.sel   = f[7][4:0];
                    v.data  = f[8];
                    v.delay = f[9][3:0];
                    v.xreq  = f[10][1:0];
                    v.xpc   = f[11];
                    v.xepc  = f[12];
                    v.xcode = f[13][4:0];
                    v.xbd   = f[14][0];
                    tests[count] = v;
                    if (int'(v.delay) > worst_delay) begin
                        worst_delay = v.delay;
                    end
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Read port is combinational, so the checker samples it on the next rising edge.
    task automatic check_read(input cp0_sel_t sel, input word_t expected);
        cp0_rd_sel = sel;
        rd_exp     = expected;
        rd_check   = 1'b1;
        @(negedge clk);
        rd_check   = 1'b0;
    endtask

    task automatic write_cp0(input cp0_sel_t sel, input word_t data);
        cp0_wr.en   = 1'b1;
        cp0_wr.sel  = sel;
        cp0_wr.data = data;
        @(negedge clk);
        cp0_wr.en   = 1'b0;
    endtask

    task automatic drive_redirect(input test_vec_t v);
        exe.valid     = 1'b1;
        exe.pc        = v.pc;
        exe.exc_chk   = exc_chk_e'(v.chk);
        exe.trap_cond = trap_cond_e'(v.cond);
        exe.rs_value  = v.rs;
        exe.rt_value  = v.rt;
        mem.valid     = v.mval;
        mem.pc_src    = pc_src_e'(v.psrc);
        if (v.xreq == 2'd0) begin
            repeat (3) @(negedge clk);
            exe.valid = 1'b0;
            mem.valid = 1'b0;
        end else begin
            // A held exception waits for the running handshake to finish.
            while (stall) @(negedge clk);
            while (!stall) @(negedge clk);
            if (v.xreq == 2'd1) begin
                exe.valid = 1'b0;
                mem.valid = 1'b0;
                while (stall) @(negedge clk);
            end
        end
        if (v.xreq != 2'd2) begin
            check_read(CP0_EPC, v.xepc);
            check_read(CP0_CAUSE, {v.xbd, 24'h0, v.xcode, 2'b00});
        end
    endtask

    task automatic finish_test(input int idx);
        @(negedge clk);
        test_num  = idx;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_vec_t v;
        v = tests[idx];
        @(negedge clk);
        test_num  = idx;
        exp_req   = (v.op == OP_REDIRECT) && (v.xreq != 2'd0);
        exp_pc    = v.xpc;
        ack_delay = v.delay;
        case (v.op)
            OP_WRITE: begin
                write_cp0(v.sel, v.data);
            end
            OP_READ: begin
                check_read(v.sel, v.data);
            end
            default: begin
                drive_redirect(v);
            end
        endcase
        finish_test(idx);
    endtask

    // Fetch stage answers each request after the test's ack delay.
    initial begin : fetch_stage
        redirect_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (redirect_req && !redirect_ack) begin
                repeat (ack_delay) @(negedge clk);
                redirect_ack = 1'b1;
                while (redirect_req) @(negedge clk);
                redirect_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int worst_delay;
        exe         = '0;
        mem         = '0;
        cp0_wr      = '0;
        cp0_rd_sel  = '0;
        exp_req     = 1'b0;
        exp_pc      = '0;
        rd_check    = 1'b0;
        rd_exp      = '0;
        test_done   = 1'b0;
        test_num    = 0;
        ack_delay   = 0;
        cycle_limit = 0;
        load_tests(num_tests, worst_delay);
        if (num_tests <= 0) begin
            $display("no test could be read from dv/exception_unit_tests.txt");
            $display("Test failed");
            $finish;
        end else begin
            cycle_limit = num_tests * (worst_delay + 20);
            @(posedge rst_n);
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            repeat (2) @(negedge clk);
            $display("%0d tests: %0d passed, %0d failed", num_tests, pass_count, fail_count);
            if ((error_total == 0) && (pass_count == num_tests)) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
                $display("timeout after %0d cycles, the DUT stopped responding", cycles);
                $display("Test failed");
                $finish;
            end
        end
    end

endmodule

// File: exception_unit.f
hw/cop0_pkg.sv
hw/trap_evaluator.sv
hw/exception_controller.sv
hw/cop0_regs.sv
hw/redirect_handshake.sv
hw/exception_unit.sv
dv/tb_clock_gen.sv
dv/exception_unit_checker.sv
dv/exception_unit_tb.sv

// File: dv/exception_unit_tests.txt
# op pc chk cond rs rt mval psrc sel data delay xreq xpc xepc xcode xbd (all hex)
# chk 1 syscall 2 break 3 trap 4 eret, read/write use sel and data, xreq 2 leaves exe held
read 00000000 0 0 00000000 00000000 0 0 0c 00400000 0 0 00000000 00000000 00 0
exc  00001000 1 0 00000000 00000000 0 0 00 00000000 0 1 bfc00380 00001000 08 0
eret 00001004 4 0 00000000 00000000 0 0 00 00000000 1 1 00001000 00001000 08 0
exc  00001010 2 0 00000000 00000000 0 1 00 00000000 2 1 bfc00380 00001010 09 0
eret 00001014 4 0 00000000 00000000 0 0 00 00000000 3 1 00001010 00001010 09 0
exc  00002000 3 0 00000005 00000006 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 1 00000007 00000007 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 2 ffffffff 00000001 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 3 00000001 ffffffff 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 4 00000001 ffffffff 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 5 ffffffff 00000001 0 0 00 00000000 0 0 00000000 00001010 09 0
exc  00002000 3 0 00000005 00000005 0 0 00 00000000 0 1 bfc00380 00002000 0d 0
exc  00002004 3 1 00000005 00000006 0 0 00 00000000 1 1 bfc00380 00002000 0d 0
exc  00002008 3 2 00000001 ffffffff 0 0 00 00000000 2 1 bfc00380 00002000 0d 0
exc  0000200c 3 3 ffffffff 00000001 0 0 00 00000000 3 1 bfc00380 00002000 0d 0
exc  00002010 3 4 ffffffff 00000001 0 0 00 00000000 4 1 bfc00380 00002000 0d 0
exc  00002014 3 5 00000001 ffffffff 0 0 00 00000000 5 1 bfc00380 00002000 0d 0
exc  00002100 2 0 00000000 00000000 0 0 00 00000000 0 1 bfc00380 00002000 09 0
eret 00002104 4 0 00000000 00000000 0 0 00 00000000 1 1 00002000 00002000 09 0
read 00000000 0 0 00000000 00000000 0 0 0c 00400000 0 0 00000000 00000000 00 0
exc  00003004 1 0 00000000 00000000 1 1 00 00000000 4 1 bfc00380 00003000 08 1
eret 00003008 4 0 00000000 00000000 0 0 00 00000000 0 1 00003000 00003000 08 1
exc  00003104 2 0 00000000 00000000 1 2 00 00000000 5 1 bfc00380 00003100 09 1
eret 00003108 4 0 00000000 00000000 0 0 00 00000000 2 1 00003100 00003100 09 1
write 00000000 0 0 00000000 00000000 0 0 0c 00000000 0 0 00000000 00000000 00 0
write 00000000 0 0 00000000 00000000 0 0 0f 80004000 0 0 00000000 00000000 00 0
read 00000000 0 0 00000000 00000000 0 0 0f 80004000 0 0 00000000 00000000 00 0
exc  00004000 1 0 00000000 00000000 0 0 00 00000000 1 1 80004180 00004000 08 0
eret 00004004 4 0 00000000 00000000 0 0 00 00000000 0 1 00004000 00004000 08 0
exc  00005000 2 0 00000000 00000000 0 0 00 00000000 3 2 80004180 00005000 09 0
exc  00005100 1 0 00000000 00000000 0 0 00 00000000 0 1 80004180 00005000 08 0
eret 00005104 4 0 00000000 00000000 0 0 00 00000000 2 1 00005000 00005000 08 0
read 00000000 0 0 00000000 00000000 0 0 0c 00000000 0 0 00000000 00000000 00 0
